// ==== list.f ====
fetch_pkg.sv
fetch_req_if.sv
pc_gen.sv
axi_fetch_if.sv
instr_align.sv
fetch_top.sv
tb_axi_mem.sv
tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_top

sources:
  - fetch_pkg.sv
  - fetch_req_if.sv
  - pc_gen.sv
  - axi_fetch_if.sv
  - instr_align.sv
  - fetch_top.sv
  - target: test
    files:
      - tb_axi_mem.sv
      - tb_fetch_top.sv

// ==== tb_fetch_top.sv ====
`timescale 1ns/1ns

module tb_fetch_top;

    localparam int unsigned NUM_TESTS       = 4;
    localparam int unsigned CYCLES_PER_TEST = 400;

    logic clock;
    logic reset;
    logic redirect_valid_i;
    logic instr_ready_i;
    logic instr_valid_o;
    logic fetch_err_o;
    fetch_pkg::addr_t  redirect_pc_i;
    fetch_pkg::instr_t instr_o;
    fetch_pkg::addr_t  instr_pc_o;

    logic                  axi_ar_valid_o;
    logic                  axi_ar_ready_i;
    fetch_pkg::addr_t      axi_ar_addr_o;
    fetch_pkg::axi_id_t    axi_ar_id_o;
    fetch_pkg::axi_len_t   axi_ar_len_o;
    fetch_pkg::axi_size_t  axi_ar_size_o;
    fetch_pkg::axi_prot_t  axi_ar_prot_o;
    fetch_pkg::axi_burst_t axi_ar_burst_o;
    fetch_pkg::axi_cache_t axi_ar_cache_o;
    logic                  axi_r_valid_i;
    logic                  axi_r_ready_o;
    fetch_pkg::word_t      axi_r_data_i;
    fetch_pkg::axi_resp_t  axi_r_resp_i;
    logic                  axi_r_last_i;
    fetch_pkg::axi_id_t    axi_r_id_i;

    // scoreboard state
    fetch_pkg::addr_t  exp_pc;        // next pc the decoder must see
    fetch_pkg::addr_t  prev_pc;       // last accepted pc
    fetch_pkg::addr_t  ar_addr_q;
    fetch_pkg::addr_t  hold_pc;
    fetch_pkg::instr_t hold_instr;
    logic        hold_err;
    logic        hold_q;              // stalled last cycle
    logic        ar_wait_q;           // ar waited last cycle
    logic        rd_open;             // ar accepted and beat not back yet
    logic        load_q;              // output reg could load at last edge
    logic        have_prev;
    logic        redir_since;         // redirect since last accept
    logic        in_reset_q = 1'b0;
    int unsigned ar_cnt;
    int unsigned occ_ar;              // ar count when the held instr was loaded
    int unsigned prev_ar;
    int unsigned cur_ar;
    int unsigned err_cnt = 0;
    int unsigned tests_failed = 0;
    int unsigned test_no = 0;
    logic        accept;
    logic        reuse_ok;

    fetch_top UUT (.*);

    tb_axi_mem u_mem (
        .clock      (clock),
        .reset      (reset),
        .ar_valid_i (axi_ar_valid_o),
        .ar_ready_o (axi_ar_ready_i),
        .ar_addr_i  (axi_ar_addr_o),
        .r_valid_o  (axi_r_valid_i),
        .r_ready_i  (axi_r_ready_o),
        .r_data_o   (axi_r_data_i),
        .r_resp_o   (axi_r_resp_i),
        .r_last_o   (axi_r_last_i),
        .r_id_o     (axi_r_id_i)
    );

    always #4 clock = ~clock;

    function automatic fetch_pkg::instr_t instr_pattern(input fetch_pkg::addr_t a);
        return a[63:32] ^ a[31:0] ^ 32'h1357_9BDF;
    endfunction

    function automatic logic in_err_region(input fetch_pkg::addr_t a);
        return a[15:12] == 4'hF;
    endfunction

    task automatic note_failure(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    assign accept   = instr_valid_o && instr_ready_i;
    assign cur_ar   = load_q ? ar_cnt : occ_ar;
    // second half of a word without redirect must reuse the held beat
    assign reuse_ok = !(accept && have_prev && !redir_since &&
                        prev_pc[63:3] == instr_pc_o[63:3]) || (cur_ar == prev_ar);

    always @(posedge clock) in_reset_q <= !reset;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            exp_pc      <= 64'h0000_0000_8000_0000;   // boot address
            hold_q      <= 1'b0;
            ar_wait_q   <= 1'b0;
            rd_open     <= 1'b0;
            load_q      <= 1'b0;
            have_prev   <= 1'b0;
            redir_since <= 1'b0;
            ar_cnt      <= 0;
            occ_ar      <= 0;
        end else begin
            ar_wait_q  <= axi_ar_valid_o && !axi_ar_ready_i;
            ar_addr_q  <= axi_ar_addr_o;
            hold_q     <= instr_valid_o && !instr_ready_i && !redirect_valid_i;
            hold_instr <= instr_o;
            hold_pc    <= instr_pc_o;
            hold_err   <= fetch_err_o;
            load_q     <= (!instr_valid_o || instr_ready_i) && !redirect_valid_i;
            occ_ar     <= cur_ar;
            if (axi_ar_valid_o && axi_ar_ready_i) begin
                rd_open <= 1'b1;
                ar_cnt  <= ar_cnt + 1;
            end
            if (axi_r_valid_i && axi_r_ready_o) begin
                rd_open <= 1'b0;
            end
            if (accept) begin
                exp_pc      <= instr_pc_o + 64'd4;
                prev_pc     <= instr_pc_o;
                prev_ar     <= cur_ar;
                have_prev   <= 1'b1;
                redir_since <= 1'b0;
            end
            if (redirect_valid_i) begin
                exp_pc      <= redirect_pc_i;   // redirect wins
                redir_since <= 1'b1;
            end
        end
    end

    reset_chk: assert property (@(posedge clock)
        in_reset_q && !reset |-> !instr_valid_o && !axi_ar_valid_o && !axi_r_ready_o)
        else note_failure("valid outputs not low in reset");
    pattern_chk: assert property (@(posedge clock) disable iff (!reset)
        instr_valid_o && !fetch_err_o |-> instr_o == instr_pattern(instr_pc_o))
        else note_failure($sformatf("instr %h at pc %h does not match memory",
                                    $sampled(instr_o), $sampled(instr_pc_o)));
    order_chk: assert property (@(posedge clock) disable iff (!reset)
        accept |-> instr_pc_o == exp_pc)
        else note_failure($sformatf("accepted pc %h, expected %h",
                                    $sampled(instr_pc_o), $sampled(exp_pc)));
    hold_chk: assert property (@(posedge clock) disable iff (!reset)
        hold_q |-> instr_valid_o && instr_o == hold_instr &&
                   instr_pc_o == hold_pc && fetch_err_o == hold_err)
        else note_failure("decoder outputs moved under back-pressure");
    err_chk: assert property (@(posedge clock) disable iff (!reset)
        instr_valid_o |-> fetch_err_o == in_err_region(instr_pc_o))
        else note_failure($sformatf("fetch_err_o wrong for pc %h", $sampled(instr_pc_o)));
    align_chk: assert property (@(posedge clock) disable iff (!reset)
        axi_ar_valid_o |-> axi_ar_addr_o[2:0] == 3'b000)
        else note_failure("araddr not 8 byte aligned");
    ar_hold_chk: assert property (@(posedge clock) disable iff (!reset)
        ar_wait_q |-> axi_ar_valid_o && axi_ar_addr_o == ar_addr_q)
        else note_failure("arvalid dropped or araddr changed before arready");
    single_chk: assert property (@(posedge clock) disable iff (!reset)
        axi_ar_valid_o |-> !rd_open)
        else note_failure("second ar issued before the r beat");
    fields_chk: assert property (@(posedge clock) disable iff (!reset)
        axi_ar_valid_o |-> axi_ar_len_o == 8'd0 && axi_ar_size_o == 3'd3 &&
                           axi_ar_burst_o == 2'b01 &&
                           axi_ar_id_o == fetch_pkg::AXI_FETCH_ID &&
                           axi_ar_prot_o == fetch_pkg::AXI_PROT_FETCH &&
                           axi_ar_cache_o == fetch_pkg::AXI_CACHE_NONCACHE)
        else note_failure("fixed ar field wrong");
    reuse_chk: assert property (@(posedge clock) disable iff (!reset) reuse_ok)
        else note_failure($sformatf("pc %h of a held word caused a new read",
                                    $sampled(instr_pc_o)));

    // random ready and redirects until n instructions are accepted
    task automatic run_stream(input string name, input int unsigned n_acc,
                              input int unsigned ready_pct, input int unsigned redir_pct,
                              input fetch_pkg::addr_t base);
        int unsigned got;
        int unsigned err_before;
        got        = 0;
        err_before = err_cnt;
        test_no++;
        while (got < n_acc) begin
            @(posedge clock);
            if (instr_valid_o && instr_ready_i) begin
                got++;
            end
            #1;
            instr_ready_i    = ($urandom_range(99) < ready_pct);
            redirect_valid_i = ($urandom_range(99) < redir_pct);
            redirect_pc_i    = base + (fetch_pkg::addr_t'($urandom_range(255)) << 2);
        end
        if (err_cnt != err_before) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d accepted, %0d check failures",
                 test_no, name, got, err_cnt - err_before);
    endtask

    task automatic redirect_to(input fetch_pkg::addr_t target);
        @(posedge clock);
        #1;
        redirect_valid_i = 1'b1;
        redirect_pc_i    = target;
        @(posedge clock);
        #1;
        redirect_valid_i = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h68b0));
        clock            = 1'b0;
        reset            = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        instr_ready_i    = 1'b0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b1;
        run_stream("sequential stream", 32, 100, 0, '0);
        run_stream("back-pressure", 24, 40, 0, '0);
        run_stream("random redirects", 20, 70, 5, 64'h0000_0000_8000_0400);
        redirect_to(64'h0000_0000_8000_FFE8);    // runs out of the slverr region
        run_stream("error region", 16, 70, 0, '0);
        $display("summary: %0d tests, %0d failed, %0d check failures",
                 test_no, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // hang guard
    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST + 8) @(posedge clock);
        $display("watchdog: run did not finish in %0d cycles, fetch path seems stuck",
                 NUM_TESTS * CYCLES_PER_TEST + 8);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== tb_axi_mem.sv ====
`timescale 1ns/1ns

module tb_axi_mem (
    input  logic                 clock,
    input  logic                 reset,        // async active low
    input  logic                 ar_valid_i,
    output logic                 ar_ready_o,
    input  fetch_pkg::addr_t     ar_addr_i,
    output logic                 r_valid_o,
    input  logic                 r_ready_i,
    output fetch_pkg::word_t     r_data_o,
    output fetch_pkg::axi_resp_t r_resp_o,
    output logic                 r_last_o,
    output fetch_pkg::axi_id_t   r_id_o
);

    function automatic logic [31:0] word_pattern(input fetch_pkg::addr_t a);
        return a[63:32] ^ a[31:0] ^ 32'h1357_9BDF;   // upper half folded in
    endfunction

    // one read at a time with ready and valid each late by 0..5 cycles
    initial begin
        fetch_pkg::addr_t addr;
        int unsigned      delay;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_data_o   = '0;
        r_resp_o   = 2'b00;
        r_last_o   = 1'b0;
        r_id_o     = '0;
        forever begin
            @(posedge clock);
            if (reset && ar_valid_i) begin
                delay = $urandom_range(5);
                repeat (delay) @(posedge clock);
                #1;
                ar_ready_o = 1'b1;
                @(posedge clock);          // ar handshake at this edge
                addr = ar_addr_i;
                #1;
                ar_ready_o = 1'b0;
                delay = $urandom_range(5);
                repeat (delay) @(posedge clock);
                #1;
                // each 32 bit word holds its folded byte address xor a constant
                r_data_o  = {word_pattern(addr + 64'd4), word_pattern(addr)};
                r_resp_o  = (addr[15:12] == 4'hF) ? 2'b10 : 2'b00;   // slverr region
                r_last_o  = 1'b1;                                     // single beat
                r_id_o    = 4'h0;
                r_valid_o = 1'b1;
                do begin
                    @(posedge clock);
                end while (!r_ready_i);
                #1;
                r_valid_o = 1'b0;
                r_last_o  = 1'b0;
            end
        end
    end

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top (
    input  logic                   clock,
    input  logic                   reset,            // async, active low

    // back end
    input  logic                   redirect_valid_i,
    input  fetch_pkg::addr_t       redirect_pc_i,
    input  logic                   instr_ready_i,
    output logic                   instr_valid_o,
    output fetch_pkg::instr_t      instr_o,
    output fetch_pkg::addr_t       instr_pc_o,
    output logic                   fetch_err_o,

    // axi ar
    output logic                   axi_ar_valid_o,
    input  logic                   axi_ar_ready_i,
    output fetch_pkg::addr_t       axi_ar_addr_o,
    output fetch_pkg::axi_id_t     axi_ar_id_o,
    output fetch_pkg::axi_len_t    axi_ar_len_o,
    output fetch_pkg::axi_size_t   axi_ar_size_o,
    output fetch_pkg::axi_prot_t   axi_ar_prot_o,
    output fetch_pkg::axi_burst_t  axi_ar_burst_o,
    output fetch_pkg::axi_cache_t  axi_ar_cache_o,

    // axi r
    input  logic                   axi_r_valid_i,
    output logic                   axi_r_ready_o,
    input  fetch_pkg::word_t       axi_r_data_i,
    input  fetch_pkg::axi_resp_t   axi_r_resp_i,
    input  logic                   axi_r_last_i,
    input  fetch_pkg::axi_id_t     axi_r_id_i
);

    fetch_req_if req_bus ();   // pc -> bus unit -> align

    pc_gen u_pc_gen (
        .clock            (clock),
        .reset            (reset),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .req              (req_bus.gen)
    );

    axi_fetch_if u_axi_fetch_if (
        .clock          (clock),
        .reset          (reset),
        .req            (req_bus.fetch),
        .axi_ar_valid_o (axi_ar_valid_o),
        .axi_ar_ready_i (axi_ar_ready_i),
        .axi_ar_addr_o  (axi_ar_addr_o),
        .axi_ar_id_o    (axi_ar_id_o),
        .axi_ar_len_o   (axi_ar_len_o),
        .axi_ar_size_o  (axi_ar_size_o),
        .axi_ar_prot_o  (axi_ar_prot_o),
        .axi_ar_burst_o (axi_ar_burst_o),
        .axi_ar_cache_o (axi_ar_cache_o),
        .axi_r_valid_i  (axi_r_valid_i),
        .axi_r_ready_o  (axi_r_ready_o),
        .axi_r_data_i   (axi_r_data_i),
        .axi_r_resp_i   (axi_r_resp_i),
        .axi_r_last_i   (axi_r_last_i),
        .axi_r_id_i     (axi_r_id_i)
    );

    instr_align u_instr_align (
        .clock            (clock),
        .reset            (reset),
        .rsp              (req_bus.align),
        .redirect_valid_i (redirect_valid_i),
        .instr_ready_i    (instr_ready_i),
        .instr_valid_o    (instr_valid_o),
        .instr_o          (instr_o),
        .instr_pc_o       (instr_pc_o),
        .fetch_err_o      (fetch_err_o)
    );

endmodule

// ==== instr_align.sv ====
`timescale 1ns/1ns

module instr_align (
    input  logic              clock,
    input  logic              reset,             // async, active low
    fetch_req_if.align        rsp,
    input  logic              redirect_valid_i,  // flush the output reg
    input  logic              instr_ready_i,     // decoder can accept
    output logic              instr_valid_o,
    output fetch_pkg::instr_t instr_o,
    output fetch_pkg::addr_t  instr_pc_o,
    output logic              fetch_err_o
);

    logic              slot_free;    // output reg empty or draining this cycle
    logic              take;
    logic              hi_half;
    fetch_pkg::instr_t half;

    assign slot_free = !instr_valid_o || instr_ready_i;

    // nothing from the old path is taken on a redirect cycle
    assign take = rsp.resp_valid && slot_free && !redirect_valid_i;
    assign rsp.resp_take = take;

    // little endian, pc bit 2 selects the upper word
    assign hi_half = rsp.req_addr[fetch_pkg::WORD_OFFSET_W-1];
    assign half    = hi_half ? rsp.resp_data[fetch_pkg::WORD_W-1:fetch_pkg::INSTR_W]
                             : rsp.resp_data[fetch_pkg::INSTR_W-1:0];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            instr_valid_o <= 1'b0;
        end else if (redirect_valid_i) begin
            instr_valid_o <= 1'b0;         // drop wrong-path instr
        end else if (take) begin
            instr_valid_o <= 1'b1;
        end else if (instr_ready_i) begin
            instr_valid_o <= 1'b0;         // drained, nothing new
        end
    end

    // payload only moves on take, so it holds under back-pressure
    always_ff @(posedge clock) begin
        if (take) begin
            instr_o     <= half;
            instr_pc_o  <= rsp.req_addr;   // pc of this instr, not the word
            fetch_err_o <= rsp.resp_err;
        end
    end

endmodule

// ==== axi_fetch_if.sv ====
`timescale 1ns/1ns

module axi_fetch_if (
    input  logic                   clock,
    input  logic                   reset,           // async, active low
    fetch_req_if.fetch             req,

    // read address channel
    output logic                   axi_ar_valid_o,
    input  logic                   axi_ar_ready_i,
    output fetch_pkg::addr_t       axi_ar_addr_o,
    output fetch_pkg::axi_id_t     axi_ar_id_o,
    output fetch_pkg::axi_len_t    axi_ar_len_o,
    output fetch_pkg::axi_size_t   axi_ar_size_o,
    output fetch_pkg::axi_prot_t   axi_ar_prot_o,
    output fetch_pkg::axi_burst_t  axi_ar_burst_o,
    output fetch_pkg::axi_cache_t  axi_ar_cache_o,

    // read data channel
    input  logic                   axi_r_valid_i,
    output logic                   axi_r_ready_o,
    input  fetch_pkg::word_t       axi_r_data_i,
    input  fetch_pkg::axi_resp_t   axi_r_resp_i,
    input  logic                   axi_r_last_i,
    input  fetch_pkg::axi_id_t     axi_r_id_i
);

    fetch_pkg::fetch_state_e state_q;
    fetch_pkg::fetch_state_e state_d;

    fetch_pkg::addr_t req_word;    // request rounded down to the beat
    fetch_pkg::addr_t addr_q;      // word in flight or held
    fetch_pkg::word_t data_q;      // held beat
    logic             err_q;       // held beat came back bad
    logic             word_hit;
    logic             beat_fire;
    logic             load_addr;

    // compare on 8 byte granularity, second instr of a word needs no read
    assign req_word = {req.req_addr[fetch_pkg::ADDR_W-1:fetch_pkg::WORD_OFFSET_W],
                       {fetch_pkg::WORD_OFFSET_W{1'b0}}};
    assign word_hit  = (req_word == addr_q);
    assign beat_fire = axi_r_valid_i && axi_r_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::FETCH_IDLE: begin
                if (req.req_valid) begin
                    state_d = fetch_pkg::FETCH_AR_WAIT;
                end
            end
            fetch_pkg::FETCH_AR_WAIT: begin
                if (axi_ar_ready_i) begin
                    state_d = fetch_pkg::FETCH_R_WAIT;   // addr accepted
                end
            end
            fetch_pkg::FETCH_R_WAIT: begin
                if (beat_fire && axi_r_last_i) begin
                    state_d = fetch_pkg::FETCH_DONE;
                end
            end
            fetch_pkg::FETCH_DONE: begin
                if (!req.req_valid) begin
                    state_d = fetch_pkg::FETCH_IDLE;
                end else if (!word_hit) begin
                    state_d = fetch_pkg::FETCH_AR_WAIT;  // pc left the word, refetch
                end
            end
            default: begin
                state_d = fetch_pkg::FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= fetch_pkg::FETCH_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // address frozen on entry to ar_wait so araddr stays stable during the wait
    assign load_addr = (state_d == fetch_pkg::FETCH_AR_WAIT) &&
                       (state_q != fetch_pkg::FETCH_AR_WAIT);

    always_ff @(posedge clock) begin
        if (load_addr) begin
            addr_q <= req_word;
        end
        if (beat_fire) begin
            data_q <= axi_r_data_i;
            // slverr / decerr, or a beat that is not ours
            err_q  <= (axi_r_resp_i != fetch_pkg::AXI_RESP_OKAY) ||
                      (axi_r_id_i != fetch_pkg::AXI_FETCH_ID);
        end
    end

    // response is a level, only for the word actually held
    assign req.resp_valid = (state_q == fetch_pkg::FETCH_DONE) && word_hit;
    assign req.resp_data  = data_q;
    assign req.resp_err   = err_q;

    // handshakes straight from state, low in reset
    assign axi_ar_valid_o = (state_q == fetch_pkg::FETCH_AR_WAIT);
    assign axi_r_ready_o  = (state_q == fetch_pkg::FETCH_R_WAIT);

    assign axi_ar_addr_o  = addr_q;
    assign axi_ar_id_o    = fetch_pkg::AXI_FETCH_ID;
    assign axi_ar_len_o   = fetch_pkg::AXI_LEN_SINGLE;     // one beat
    assign axi_ar_size_o  = fetch_pkg::AXI_SIZE_BEAT;
    assign axi_ar_prot_o  = fetch_pkg::AXI_PROT_FETCH;
    assign axi_ar_burst_o = fetch_pkg::AXI_BURST_INCR;
    assign axi_ar_cache_o = fetch_pkg::AXI_CACHE_NONCACHE;

endmodule

// ==== pc_gen.sv ====
`timescale 1ns/1ns

module pc_gen (
    input  logic             clock,
    input  logic             reset,             // async, active low
    input  logic             redirect_valid_i,  // branch / trap from the back end
    input  fetch_pkg::addr_t redirect_pc_i,
    fetch_req_if.gen         req
);

    fetch_pkg::addr_t pc_q;
    fetch_pkg::addr_t pc_next;
    logic             run_q;     // goes high the first cycle out of reset

    // sequential successor, no prediction
    assign pc_next = pc_q + fetch_pkg::addr_t'(fetch_pkg::INSTR_STEP);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;   // fetch never stops once started
        end
    end

    // redirect wins over the sequential step
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc_q <= fetch_pkg::RESET_PC;
        end else if (redirect_valid_i) begin
            pc_q <= redirect_pc_i;
        end else if (req.resp_take) begin
            pc_q <= pc_next;     // instr taken, move on
        end
    end

    // pc holds while the align stage is stalled

    assign req.req_valid = run_q;
    assign req.req_addr  = pc_q;     // straight from the register, stable within a cycle

endmodule

// ==== fetch_req_if.sv ====
`timescale 1ns/1ns

interface fetch_req_if;

    // request side, from the pc stage
    logic             req_valid;
    fetch_pkg::addr_t req_addr;     // byte address of wanted instr

    // response side, held word from the bus unit
    logic             resp_valid;   // level, word matches req_addr
    fetch_pkg::word_t resp_data;
    logic             resp_err;     // bus error on that word
    logic             resp_take;    // one cycle strobe from align stage

    modport gen (
        output req_valid,
        output req_addr,
        input  resp_take       // advance pc
    );

    modport fetch (
        input  req_valid,
        input  req_addr,
        output resp_valid,
        output resp_data,
        output resp_err
    );

    modport align (
        input  req_addr,       // bit 2 picks the half, full value is the pc
        input  resp_valid,
        input  resp_data,
        input  resp_err,
        output resp_take
    );

endinterface

// ==== fetch_pkg.sv ====
package fetch_pkg;

    // widths of the fetch path
    localparam int unsigned ADDR_W  = 64;   // byte address
    localparam int unsigned WORD_W  = 64;   // one axi data beat
    localparam int unsigned INSTR_W = 32;   // rv64 base instruction without rvc
    localparam int unsigned ID_W    = 4;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [ID_W-1:0]    axi_id_t;

    // axi read address and response fields
    typedef logic [7:0] axi_len_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;
    typedef logic [2:0] axi_prot_t;
    typedef logic [3:0] axi_cache_t;
    typedef logic [1:0] axi_resp_t;

    localparam addr_t RESET_PC = 64'h0000_0000_8000_0000;   // boot address

    localparam int unsigned WORD_OFFSET_W = $clog2(WORD_W / 8);  // byte offset bits in a beat
    localparam int unsigned INSTR_STEP    = INSTR_W / 8;         // sequential pc advance

    // fixed ar fields for a single beat fetch
    localparam axi_id_t    AXI_FETCH_ID       = 4'h0;
    localparam axi_len_t   AXI_LEN_SINGLE     = 8'd0;
    localparam axi_size_t  AXI_SIZE_BEAT      = 3'd3;     // 8 bytes
    localparam axi_burst_t AXI_BURST_INCR     = 2'b01;
    localparam axi_prot_t  AXI_PROT_FETCH     = 3'b100;   // unprivileged secure instruction access
    localparam axi_cache_t AXI_CACHE_NONCACHE = 4'b0000;  // device non bufferable
    localparam axi_resp_t  AXI_RESP_OKAY      = 2'b00;

    // read fsm in gray code
    typedef enum logic [1:0] {
        FETCH_IDLE    = 2'b00,
        FETCH_AR_WAIT = 2'b01,   // ar_valid up until ar_ready
        FETCH_R_WAIT  = 2'b11,   // r_ready up until the beat
        FETCH_DONE    = 2'b10    // word held and served while address matches
    } fetch_state_e;

endpackage
